// ==== hw/pixel_compose.sv ====
`default_nettype none

module pixel_compose (
	input  logic clk,
	input  logic rst,
	// Quasi-static palette banks
	input  logic [ppu_pkg::palette_bits-1:0] bg_palette,
	input  logic [ppu_pkg::palette_bits-1:0] sprite_palette,
	tile_job_if.sink in,
	pixel_row_if.source out
);

	logic in_fire;
	logic out_valid;
	ppu_pkg::pixel_colours_t next_colours;

	// Priority and palette lookup for one pixel
	function automatic ppu_pkg::colour_t pick_colour(input logic [1:0] bg_v,
		input logic [1:0] sp_v, input logic [1:0] bg_pal, input logic [1:0] sp_pal,
		input logic behind, input logic [ppu_pkg::palette_bits-1:0] bg_bank,
		input logic [ppu_pkg::palette_bits-1:0] sp_bank);
		logic sp_wins;
		// Opaque sprite wins unless it sits behind opaque background
		sp_wins = (sp_v != 2'b00) && (!behind || bg_v == 2'b00);
		if (sp_wins) begin
			return sp_bank[{sp_pal, sp_v} * 8 +: 8];
		end
		if (bg_v != 2'b00) begin
			return bg_bank[{bg_pal, bg_v} * 8 +: 8];
		end
		// Backdrop colour
		return bg_bank[7:0];
	endfunction

	// Bit 7 of each pattern byte is pixel 0
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			next_colours[i] = pick_colour({in.bg_hi[7-i], in.bg_lo[7-i]},
				{in.sp_hi[7-i], in.sp_lo[7-i]}, in.bg_pal, in.sp_pal,
				in.sp_behind, bg_palette, sprite_palette);
		end
	end

	// Accept when empty or when the held row leaves this cycle
	assign in.ready = !out_valid || out.ready;
	assign in_fire = in.valid && in.ready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			out_valid <= 1'b0;
		end else if (in_fire) begin
			out_valid <= 1'b1;
		end else if (out.ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			out.row <= in.row;
			out.col <= in.col;
			out.colours <= next_colours;
		end
	end

	assign out.valid = out_valid;

endmodule

`default_nettype wire

// ==== hw/pixel_render.sv ====
`default_nettype none

module pixel_render (
	input  logic clk,
	input  logic rst,
	pixel_row_if.sink in,
	// Frame-buffer write port
	output logic pix_valid,
	input  logic pix_ready,
	output logic [ppu_pkg::screen_coord_w-1:0] pix_row,
	output logic [ppu_pkg::screen_coord_w-1:0] pix_col,
	output logic [7:0] pix_colour
);

	// A row is being written out
	logic busy;
	// Pixel within the slice
	logic [2:0] idx;
	logic pix_fire;
	logic last_pix;
	logic in_fire;

	logic [ppu_pkg::screen_coord_w-1:0] row_q;
	logic [ppu_pkg::screen_coord_w-1:0] col_q;
	ppu_pkg::pixel_colours_t colours_q;

	assign pix_fire = pix_valid && pix_ready;
	assign last_pix = pix_fire && (idx == 3'd7);

	// Next row may enter on the final pixel handshake
	assign in.ready = !busy || last_pix;
	assign in_fire = in.valid && in.ready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			idx <= '0;
		end else if (in_fire) begin
			busy <= 1'b1;
			idx <= '0;
		end else if (pix_fire) begin
			// Eighth pixel empties the stage
			if (idx == 3'd7) begin
				busy <= 1'b0;
			end
			idx <= idx + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			row_q <= in.row;
			col_q <= in.col;
			colours_q <= in.colours;
		end
	end

	// Present the current pixel, left to right
	assign pix_valid = busy;
	assign pix_row = row_q;
	assign pix_col = col_q + idx;
	assign pix_colour = colours_q[idx];

	// Stalled pixel holds its address and colour
	a_pix_stall_hold: assert property (@(posedge clk) disable iff (!rst)
		pix_valid && !pix_ready |=>
		pix_valid && $stable(pix_row) && $stable(pix_col) && $stable(pix_colour));

endmodule

`default_nettype wire

// ==== hw/ppu_links.sv ====
`default_nettype none

// Fetched tile slice on its way to the compose stage
interface tile_job_if;
	logic valid;
	logic ready;
	logic [ppu_pkg::screen_coord_w-1:0] row;
	logic [ppu_pkg::screen_coord_w-1:0] col;
	// Background pattern bytes, bit 7 is the leftmost pixel
	logic [7:0] bg_lo;
	logic [7:0] bg_hi;
	logic [1:0] bg_pal;
	// Sprite pattern bytes already aligned to the tile
	logic [7:0] sp_lo;
	logic [7:0] sp_hi;
	logic [1:0] sp_pal;
	// Sprite drawn behind opaque background
	logic sp_behind;

	modport source(output valid, row, col, bg_lo, bg_hi, bg_pal,
		sp_lo, sp_hi, sp_pal, sp_behind, input ready);
	modport sink(input valid, row, col, bg_lo, bg_hi, bg_pal,
		sp_lo, sp_hi, sp_pal, sp_behind, output ready);
endinterface

// Eight resolved colour bytes on their way to the render stage
interface pixel_row_if;
	logic valid;
	logic ready;
	logic [ppu_pkg::screen_coord_w-1:0] row;
	logic [ppu_pkg::screen_coord_w-1:0] col;
	ppu_pkg::pixel_colours_t colours;

	modport source(output valid, row, col, colours, input ready);
	modport sink(input valid, row, col, colours, output ready);
endinterface

`default_nettype wire

// ==== hw/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

	// Video RAM address width for the 16 KB space
	localparam int vram_aw = 14;

	// Memory map
	// Nametable holds one tile number per 8x8 screen tile
	localparam logic [vram_aw-1:0] nametable_base = 14'h2000;

	// Attribute table follows the 960 nametable bytes
	localparam logic [vram_aw-1:0] attr_base = 14'h23C0;

	// Second pattern table sits this far above the first
	localparam logic [vram_aw-1:0] pattern_table_size = 14'h1000;

	// One palette bank
	// Four palettes of four colour bytes
	// Byte k of the bank sits at bits k*8 upward
	localparam int palette_bits = 128;

	// Screen row and column width
	localparam int screen_coord_w = 9;

	// One palette colour byte
	typedef logic [7:0] colour_t;

	// Eight colour bytes of one tile slice
	// Index 0 is the leftmost pixel
	typedef colour_t [7:0] pixel_colours_t;

endpackage

`default_nettype wire

// ==== hw/ppu_tile_pipe.sv ====
`default_nettype none

module ppu_tile_pipe (
	input  logic clk,
	input  logic rst,
	// Video RAM load
	input  logic vram_we,
	input  logic [ppu_pkg::vram_aw-1:0] vram_waddr,
	input  logic [7:0] vram_wdata,
	// Tile request
	input  logic req_valid,
	output logic req_ready,
	input  logic [ppu_pkg::screen_coord_w-1:0] req_row,
	input  logic [ppu_pkg::screen_coord_w-1:0] req_col,
	input  logic req_show_bg,
	input  logic req_show_sprite,
	input  logic req_bg_table,
	input  logic req_sp_table,
	input  logic req_sprite_valid,
	input  logic [7:0] req_sprite_x,
	input  logic [7:0] req_sprite_y,
	input  logic [7:0] req_sprite_tile,
	input  logic [7:0] req_sprite_attr,
	// Palettes, changed only while idle
	input  logic [ppu_pkg::palette_bits-1:0] bg_palette,
	input  logic [ppu_pkg::palette_bits-1:0] sprite_palette,
	// Pixel output
	output logic pix_valid,
	input  logic pix_ready,
	output logic [ppu_pkg::screen_coord_w-1:0] pix_row,
	output logic [ppu_pkg::screen_coord_w-1:0] pix_col,
	output logic [7:0] pix_colour
);

	logic [ppu_pkg::vram_aw-1:0] rd_addr;
	logic [7:0] rd_data;

	// Fetch to compose, compose to render
	tile_job_if job_link();
	pixel_row_if row_link();

	vram i_vram (
		.clk(clk), .rst(rst),
		.we(vram_we), .waddr(vram_waddr), .wdata(vram_wdata),
		.rd_addr(rd_addr), .rd_data(rd_data)
	);

	tile_fetch i_tile_fetch (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_ready(req_ready),
		.req_row(req_row), .req_col(req_col),
		.req_show_bg(req_show_bg), .req_show_sprite(req_show_sprite),
		.req_bg_table(req_bg_table), .req_sp_table(req_sp_table),
		.req_sprite_valid(req_sprite_valid),
		.req_sprite_x(req_sprite_x), .req_sprite_y(req_sprite_y),
		.req_sprite_tile(req_sprite_tile), .req_sprite_attr(req_sprite_attr),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.job(job_link.source)
	);

	pixel_compose i_pixel_compose (
		.clk(clk), .rst(rst),
		.bg_palette(bg_palette), .sprite_palette(sprite_palette),
		.in(job_link.sink), .out(row_link.source)
	);

	pixel_render i_pixel_render (
		.clk(clk), .rst(rst),
		.in(row_link.sink),
		.pix_valid(pix_valid), .pix_ready(pix_ready),
		.pix_row(pix_row), .pix_col(pix_col), .pix_colour(pix_colour)
	);

endmodule

`default_nettype wire

// ==== hw/tile_fetch.sv ====
`default_nettype none

module tile_fetch (
	input  logic clk,
	input  logic rst,
	// Tile request
	input  logic req_valid,
	output logic req_ready,
	input  logic [ppu_pkg::screen_coord_w-1:0] req_row,
	input  logic [ppu_pkg::screen_coord_w-1:0] req_col,
	input  logic req_show_bg,
	input  logic req_show_sprite,
	input  logic req_bg_table,
	input  logic req_sp_table,
	input  logic req_sprite_valid,
	input  logic [7:0] req_sprite_x,
	input  logic [7:0] req_sprite_y,
	input  logic [7:0] req_sprite_tile,
	input  logic [7:0] req_sprite_attr,
	// Video RAM read port
	output logic [ppu_pkg::vram_aw-1:0] rd_addr,
	input  logic [7:0] rd_data,
	tile_job_if.source job
);

	// Each read state names the address it drives
	typedef enum logic [3:0] {
		st_idle, st_nt, st_at, st_pl, st_ph, st_sl, st_sh, st_drain, st_done
	} state_t;

	state_t state;
	// Which read is returning on rd_data this cycle
	state_t last_rd;

	logic req_fire;
	logic [ppu_pkg::screen_coord_w-1:0] sp_y_ext;
	logic [ppu_pkg::screen_coord_w-1:0] sp_dy;
	logic sp_hit;
	logic [ppu_pkg::vram_aw-1:0] sp_pat_addr;

	// Request fields held for the whole fetch
	logic [ppu_pkg::screen_coord_w-1:0] row_q;
	logic [ppu_pkg::screen_coord_w-1:0] col_q;
	logic bg_table_q;
	logic sp_hit_q;
	logic sp_hflip_q;
	logic [7:0] sp_x_q;
	logic [ppu_pkg::vram_aw-1:0] sp_addr_q;
	logic [7:0] tile_q;

	logic [ppu_pkg::vram_aw-1:0] nt_addr;
	logic [ppu_pkg::vram_aw-1:0] at_addr;
	logic [ppu_pkg::vram_aw-1:0] bg_pat_addr;
	// Tile column minus sprite x
	logic signed [9:0] sp_dx;

	// Mirror if asked, then slide the sprite row under the tile
	// Bit 7 of the result is the tile's leftmost pixel
	function automatic logic [7:0] align_sprite(input logic [7:0] pat,
		input logic hflip, input logic signed [9:0] dx);
		logic [7:0] src;
		src = hflip ? {<<{pat}} : pat;
		// Large shifts push every bit out, so far columns become zero
		if (dx >= 0) begin
			return src << dx;
		end
		return src >> (-dx);
	endfunction

	assign req_ready = (state == st_idle);
	assign req_fire = req_valid && req_ready;

	// Sprite row test on the incoming request
	assign sp_y_ext = req_sprite_y;
	assign sp_dy = req_row - sp_y_ext;
	assign sp_hit = req_show_sprite && req_sprite_valid &&
		(req_row >= sp_y_ext) && (sp_dy < 8);

	// Fine row flips with vertical mirror
	assign sp_pat_addr = (req_sp_table ? ppu_pkg::pattern_table_size : '0) +
		{req_sprite_tile, 4'b0000} + (sp_dy[2:0] ^ {3{req_sprite_attr[7]}});

	// One nametable byte per tile, 32 tiles per row
	assign nt_addr = ppu_pkg::nametable_base +
		{row_q[ppu_pkg::screen_coord_w-1:3], 5'b00000} + col_q[ppu_pkg::screen_coord_w-1:3];
	// One attribute byte per 32x32 block, 8 blocks per row
	assign at_addr = ppu_pkg::attr_base +
		{row_q[ppu_pkg::screen_coord_w-1:5], 3'b000} + col_q[ppu_pkg::screen_coord_w-1:5];
	assign bg_pat_addr = (bg_table_q ? ppu_pkg::pattern_table_size : '0) +
		{tile_q, 4'b0000} + row_q[2:0];
	assign sp_dx = $signed({1'b0, col_q}) - $signed({2'b00, sp_x_q});

	always_comb begin
		case (state)
			st_nt: rd_addr = nt_addr;
			st_at: rd_addr = at_addr;
			st_pl: rd_addr = bg_pat_addr;
			// High plane is eight bytes above the low plane
			st_ph: rd_addr = bg_pat_addr + 4'd8;
			st_sl: rd_addr = sp_addr_q;
			st_sh: rd_addr = sp_addr_q + 4'd8;
			default: rd_addr = '0;
		endcase
	end

	// Sequencer
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
			last_rd <= st_idle;
		end else begin
			last_rd <= (state inside {st_nt, st_at, st_pl, st_ph, st_sl, st_sh}) ?
				state : st_idle;
			case (state)
				st_idle: begin
					if (req_valid) begin
						// Skip straight to whichever layer needs reads
						if (req_show_bg) begin
							state <= st_nt;
						end else if (sp_hit) begin
							state <= st_sl;
						end else begin
							state <= st_done;
						end
					end
				end
				st_nt: state <= st_at;
				st_at: state <= st_pl;
				st_pl: state <= st_ph;
				st_ph: state <= sp_hit_q ? st_sl : st_drain;
				st_sl: state <= st_sh;
				// Last read still in flight
				st_sh: state <= st_drain;
				st_drain: state <= st_done;
				st_done: begin
					if (job.ready) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Request capture and read-data capture
	always_ff @(posedge clk) begin
		if (req_fire) begin
			row_q <= req_row;
			col_q <= req_col;
			bg_table_q <= req_bg_table;
			sp_hit_q <= sp_hit;
			sp_hflip_q <= req_sprite_attr[6];
			sp_x_q <= req_sprite_x;
			sp_addr_q <= sp_pat_addr;
			job.sp_pal <= req_sprite_attr[1:0];
			job.sp_behind <= req_sprite_attr[5];
			// Layers that are never read stay transparent
			job.bg_lo <= '0;
			job.bg_hi <= '0;
			job.bg_pal <= '0;
			job.sp_lo <= '0;
			job.sp_hi <= '0;
		end else begin
			case (last_rd)
				st_nt: tile_q <= rd_data;
				// Quadrant of the 32x32 block picks two attribute bits
				st_at: job.bg_pal <= rd_data[{row_q[4], col_q[4], 1'b0} +: 2];
				st_pl: job.bg_lo <= rd_data;
				st_ph: job.bg_hi <= rd_data;
				st_sl: job.sp_lo <= align_sprite(rd_data, sp_hflip_q, sp_dx);
				st_sh: job.sp_hi <= align_sprite(rd_data, sp_hflip_q, sp_dx);
				default: ;
			endcase
		end
	end

	assign job.valid = (state == st_done);
	assign job.row = row_q;
	assign job.col = col_q;

	// Job and its payload are held until the compose stage takes it
	a_job_held: assert property (@(posedge clk) disable iff (!rst)
		job.valid && !job.ready |=> job.valid && $stable(job.row) && $stable(job.col) &&
		$stable({job.bg_lo, job.bg_hi, job.bg_pal}) &&
		$stable({job.sp_lo, job.sp_hi, job.sp_pal, job.sp_behind}));

endmodule

`default_nettype wire

// ==== hw/vram.sv ====
`default_nettype none

module vram (
	input  logic clk,
	input  logic rst,
	// Load port
	input  logic we,
	input  logic [ppu_pkg::vram_aw-1:0] waddr,
	input  logic [7:0] wdata,
	// Fetch port, data one cycle after address
	input  logic [ppu_pkg::vram_aw-1:0] rd_addr,
	output logic [7:0] rd_data
);

	// Whole 16 KB video space
	logic [7:0] mem [0:(2 ** ppu_pkg::vram_aw)-1];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read output
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_data <= '0;
		end else begin
			rd_data <= mem[rd_addr];
		end
	end

	// Both ports stay inside the array and carry known addresses
	a_addr_in_range: assert property (@(posedge clk) disable iff (!rst)
		!$isunknown(rd_addr) && (int'(rd_addr) < 2 ** ppu_pkg::vram_aw) &&
		(!we || (!$isunknown(waddr) && int'(waddr) < 2 ** ppu_pkg::vram_aw)));

endmodule

`default_nettype wire

// ==== verification/ppu_pixel_checker.sv ====
`default_nettype none

module ppu_pixel_checker (
	input  logic clk,
	input  logic rst,
	input  logic pix_valid,
	input  logic pix_ready,
	input  logic [ppu_pkg::screen_coord_w-1:0] pix_row,
	input  logic [ppu_pkg::screen_coord_w-1:0] pix_col,
	input  logic [7:0] pix_colour
);

	// Expected pixels packed as row, column, colour
	logic [25:0] exp_q[$];
	string test_name;
	int test_errors;
	int checked;

	function automatic int pending_count();
		return exp_q.size();
	endfunction

	task automatic push_pixel(input logic [8:0] row, input logic [8:0] col,
		input logic [7:0] colour);
		exp_q.push_back({row, col, colour});
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
		checked = 0;
	endtask

	// Leftover entries mean pixels went missing
	task automatic end_test(output int errors);
		if (exp_q.size() != 0) begin
			$display("Test %s: %0d expected pixels never arrived", test_name, exp_q.size());
			test_errors++;
			exp_q.delete();
		end
		$display("Test %s finished: %0d pixels checked, %0d errors",
			test_name, checked, test_errors);
		errors = test_errors;
	endtask

	// Pixel port is stable between the falling edge and the transfer edge
	always @(negedge clk) begin : compare
		logic [25:0] want;
		if (rst && pix_valid && pix_ready) begin
			if (exp_q.size() == 0) begin
				$display("Test %s: pixel at row %0d col %0d arrived with nothing expected",
					test_name, pix_row, pix_col);
				test_errors++;
			end else begin
				want = exp_q.pop_front();
				checked++;
				// Row, column and colour must all match, in order
				if (want != {pix_row, pix_col, pix_colour}) begin
					$display("ERROR %s: expected (%0d,%0d) %02h, actual (%0d,%0d) %02h",
						test_name, want[25:17], want[16:8], want[7:0],
						pix_row, pix_col, pix_colour);
					test_errors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/tb_ppu_tile_pipe.sv ====
`default_nettype none

module tb_ppu_tile_pipe;

	localparam int clk_period = 8;
	localparam int vram_bytes = 2 ** ppu_pkg::vram_aw;
	localparam int req_count = 60;
	localparam int stress_count = 100;
	// Load time plus a per-request allowance over all five tests
	localparam int max_cycles = vram_bytes + 64 + 40 * (4 * req_count + stress_count);

	logic clk;
	logic rst;
	logic vram_we;
	logic [ppu_pkg::vram_aw-1:0] vram_waddr;
	logic [7:0] vram_wdata;
	logic req_valid;
	logic req_ready;
	logic [ppu_pkg::screen_coord_w-1:0] req_row;
	logic [ppu_pkg::screen_coord_w-1:0] req_col;
	logic req_show_bg;
	logic req_show_sprite;
	logic req_bg_table;
	logic req_sp_table;
	logic req_sprite_valid;
	logic [7:0] req_sprite_x;
	logic [7:0] req_sprite_y;
	logic [7:0] req_sprite_tile;
	logic [7:0] req_sprite_attr;
	logic [ppu_pkg::palette_bits-1:0] bg_palette;
	logic [ppu_pkg::palette_bits-1:0] sprite_palette;
	logic pix_valid;
	logic pix_ready;
	logic [ppu_pkg::screen_coord_w-1:0] pix_row;
	logic [ppu_pkg::screen_coord_w-1:0] pix_col;
	logic [7:0] pix_colour;

	logic [31:0] lfsr = 32'h9b07;
	// Sparse pix_ready in the stress test
	logic slow_ready;
	// Copies of everything loaded into the DUT
	logic [7:0] vram_copy [0:vram_bytes-1];
	logic [7:0] bg_pal_copy [0:15];
	logic [7:0] sp_pal_copy [0:15];
	int tests_failed = 0;
	int total_errors = 0;

	ppu_tile_pipe i_ppu_tile_pipe (.*);
	ppu_pixel_checker i_ppu_pixel_checker (.*);

	always #(clk_period / 2) clk = ~clk;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
		end
		return val;
	endfunction

	// Later than the request driver so the LFSR order is fixed
	always @(posedge clk) begin
		#2;
		pix_ready = slow_ready ? (rand_bits(2) == 0) : (rand_bits(1) != 0);
	end

	task automatic randomize_request(input int kind);
		req_row = rand_bits(8) % 240;
		req_col = rand_bits(5) * 8;
		req_bg_table = rand_bits(1);
		req_sp_table = rand_bits(1);
		req_sprite_valid = (rand_bits(3) != 0);
		req_sprite_tile = rand_bits(8);
		// All flip and priority bits random
		req_sprite_attr = rand_bits(8);
		// Sprite near the tile, partly off the row and off the columns
		req_sprite_x = req_col + rand_bits(4) - 8;
		req_sprite_y = req_row + rand_bits(4) - 10;
		req_show_bg = (kind == 1 || kind == 3 || kind == 5);
		req_show_sprite = (kind == 2 || kind == 3 || kind == 5);
	endtask

	// Expected eight pixels of the current request
	task automatic model_request();
		int tile;
		int attr;
		int bg_pal;
		int fine;
		int pat;
		int k;
		int b;
		logic [7:0] bg_lo;
		logic [7:0] bg_hi;
		logic [7:0] sp_lo;
		logic [7:0] sp_hi;
		logic [1:0] bv;
		logic [1:0] sv;
		logic [7:0] colour;
		logic in_row;
		{bg_lo, bg_hi, sp_lo, sp_hi} = '0;
		bg_pal = 0;
		if (req_show_bg) begin
			tile = vram_copy[32'h2000 + (req_row / 8) * 32 + req_col / 8];
			attr = vram_copy[32'h23C0 + (req_row / 32) * 8 + req_col / 32];
			// Quadrant of the 32x32 block
			bg_pal = (attr >> (((req_row % 32) / 16) * 4 + ((req_col % 32) / 16) * 2)) % 4;
			pat = req_bg_table * 4096 + tile * 16 + req_row % 8;
			bg_lo = vram_copy[pat];
			bg_hi = vram_copy[pat + 8];
		end
		in_row = req_show_sprite && req_sprite_valid && req_row >= req_sprite_y &&
			req_row < req_sprite_y + 8;
		if (in_row) begin
			fine = req_row - req_sprite_y;
			if (req_sprite_attr[7]) begin
				fine = 7 - fine;
			end
			pat = req_sp_table * 4096 + req_sprite_tile * 16 + fine;
			sp_lo = vram_copy[pat];
			sp_hi = vram_copy[pat + 8];
		end
		for (int i = 0; i < 8; i++) begin
			bv = {bg_hi[7-i], bg_lo[7-i]};
			sv = 2'b00;
			// Sprite column under this pixel
			k = req_col + i - req_sprite_x;
			if (k >= 0 && k < 8) begin
				b = req_sprite_attr[6] ? k : 7 - k;
				sv = {sp_hi[b], sp_lo[b]};
			end
			if (sv != 0 && (!req_sprite_attr[5] || bv == 0)) begin
				colour = sp_pal_copy[req_sprite_attr[1:0] * 4 + sv];
			end else if (bv != 0) begin
				colour = bg_pal_copy[bg_pal * 4 + bv];
			end else begin
				colour = bg_pal_copy[0];
			end
			i_ppu_pixel_checker.push_pixel(req_row, req_col + i, colour);
		end
	endtask

	task automatic run_test(input string name, input int kind, input int count);
		int gap;
		int errors;
		i_ppu_pixel_checker.start_test(name);
		slow_ready = (kind == 5);
		for (int n = 0; n < count; n++) begin
			// Back-to-back requests in the stress test
			gap = (kind == 5) ? 0 : rand_bits(2);
			if (gap > 0) begin
				req_valid = 1'b0;
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
			end
			randomize_request(kind);
			req_valid = 1'b1;
			// req_ready is registered, so it holds until the next edge
			while (!req_ready) begin
				@(posedge clk);
				#1;
			end
			model_request();
			@(posedge clk);
			#1;
		end
		req_valid = 1'b0;
		for (int c = 0; c < 40 * count && i_ppu_pixel_checker.pending_count() != 0; c++) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		#1;
		i_ppu_pixel_checker.end_test(errors);
		if (errors != 0) begin
			tests_failed++;
		end
		total_errors += errors;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		{vram_we, vram_waddr, vram_wdata, pix_ready, slow_ready} = '0;
		req_valid = 1'b0;
		{req_row, req_col, req_show_bg, req_show_sprite, req_bg_table, req_sp_table} = '0;
		{req_sprite_valid, req_sprite_x, req_sprite_y, req_sprite_tile, req_sprite_attr} = '0;
		for (int p = 0; p < 16; p++) begin
			bg_pal_copy[p] = rand_bits(8);
			sp_pal_copy[p] = rand_bits(8);
			bg_palette[p*8 +: 8] = bg_pal_copy[p];
			sprite_palette[p*8 +: 8] = sp_pal_copy[p];
		end
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b1;
		// Whole video space through the write port
		vram_we = 1'b1;
		for (int a = 0; a < vram_bytes; a++) begin
			vram_waddr = a;
			vram_wdata = rand_bits(8);
			vram_copy[a] = vram_wdata;
			@(posedge clk);
			#1;
		end
		vram_we = 1'b0;
		run_test("background_only", 1, req_count);
		run_test("sprite_flip_align", 2, req_count);
		run_test("priority_backdrop", 3, req_count);
		run_test("layers_disabled", 4, req_count);
		run_test("backpressure_order", 5, stress_count);
		$display("Tests run 5, tests failed %0d, errors %0d", tests_failed, total_errors);
		if (tests_failed == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(max_cycles * clk_period);
		$display("Timeout: the tests did not finish in the allowed time");
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/ppu_pkg.sv
hw/ppu_links.sv
hw/vram.sv
hw/tile_fetch.sv
hw/pixel_compose.sv
hw/pixel_render.sv
hw/ppu_tile_pipe.sv
verification/ppu_pixel_checker.sv
verification/tb_ppu_tile_pipe.sv
